// File: src/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // 50 MHz system clock at 115200 baud
  localparam int unsigned BAUD_DIV = 434;

  // idle cycles between the header and data frames of a write
  localparam int unsigned GAP_CYCLES = 100;

  // start, eight data bits, parity and stop
  localparam int unsigned FRAME_BITS = 11;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // host command, the header byte is {op, addr}
  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // err is set for a parity mismatch or a low stop bit
  typedef struct packed {
    logic [7:0] data;
    logic       err;
  } rx_frame_t;

  // read result returned to the host
  typedef struct packed {
    logic [7:0] data;
    logic       err;
  } rsp_t;

endpackage

// File: src/uart_cmd_intake.sv
`timescale 1ns/1ps

module uart_cmd_intake (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output uart_cmd_pkg::cmd_t job,
  output logic               job_vld,
  input  logic               job_rdy
);
  import uart_cmd_pkg::*;

  logic full;
  cmd_t cmd_buf;

  // a single flag tells both sides whether the slot is taken
  assign cmd_rdy = !full;
  assign job_vld = full;
  assign job     = cmd_buf;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      full <= 1'b1;
    end
    else if (job_vld && job_rdy)
    begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_buf <= cmd;
    end
  end

  // the host must hold its command while it is being stalled
  assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && !cmd_rdy) |=> (!cmd_vld || $stable(cmd)));

endmodule

// File: src/uart_cmd_sequencer.sv
`timescale 1ns/1ps

module uart_cmd_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_t      job,
  input  logic                    job_vld,
  output logic                    job_rdy,
  output logic [7:0]              byte_data,
  output logic                    byte_vld,
  input  logic                    byte_rdy,
  input  uart_cmd_pkg::rx_frame_t frame,
  input  logic                    frame_vld,
  output uart_cmd_pkg::rsp_t      rsp,
  output logic                    rsp_vld
);
  import uart_cmd_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HEAD,
    GAP,
    SEND_DATA,
    WAIT_RSP,
    REPORT
  } seq_state_e;

  typedef logic [$clog2(GAP_CYCLES)-1:0] gap_cnt_t;

  seq_state_e state;
  cmd_t       cur;
  gap_cnt_t   gap_cnt;
  logic       gap_done;

  assign job_rdy  = (state == IDLE);
  assign byte_vld = (state == SEND_HEAD) || (state == SEND_DATA);
  assign rsp_vld  = (state == REPORT);
  assign gap_done = (gap_cnt == gap_cnt_t'(GAP_CYCLES - 1));

  // header byte carries the opcode in its msb
  assign byte_data = (state == SEND_DATA) ? cur.data : {cur.op, cur.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      gap_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (job_vld)
          begin
            state <= SEND_HEAD;
          end
        end
        SEND_HEAD:
        begin
          if (byte_rdy)
          begin
            gap_cnt <= '0;
            state   <= (cur.op == OP_WRITE) ? GAP : WAIT_RSP;
          end
        end
        GAP:
        begin
          // the gap only runs once the header frame has left the serializer
          if (byte_rdy)
          begin
            if (gap_done)
            begin
              state <= SEND_DATA;
            end
            else
            begin
              gap_cnt <= gap_cnt + 1'b1;
            end
          end
        end
        SEND_DATA:
        begin
          if (byte_rdy)
          begin
            state <= IDLE;
          end
        end
        WAIT_RSP:
        begin
          if (frame_vld)
          begin
            state <= REPORT;
          end
        end
        REPORT:
        begin
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (job_vld && job_rdy)
    begin
      cur <= job;
    end
    // frames outside a read are ignored
    if ((state == WAIT_RSP) && frame_vld)
    begin
      rsp.data <= frame.data;
      rsp.err  <= frame.err;
    end
  end

  // the job latched at intake decides whether a response may ever appear
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_vld |-> (cur.op == OP_READ));

endmodule

// File: src/uart_frame_tx.sv
`timescale 1ns/1ps

module uart_frame_tx #(
  parameter int unsigned CLKS_PER_BIT = uart_cmd_pkg::BAUD_DIV
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] byte_data,
  input  logic       byte_vld,
  output logic       byte_rdy,
  output logic       tx
);
  import uart_cmd_pkg::*;

  typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;
  typedef logic [$clog2(FRAME_BITS)-1:0]   bit_cnt_t;

  logic                  busy;
  baud_cnt_t             baud_cnt;
  bit_cnt_t              bit_cnt;
  logic [FRAME_BITS-1:0] shreg;
  logic                  bit_end;

  assign byte_rdy = !busy;
  assign tx       = shreg[0];
  assign bit_end  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shreg    <= '1;
    end
    else if (!busy)
    begin
      if (byte_vld)
      begin
        busy     <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
        // stop, odd parity, data lsb first, start
        shreg    <= {1'b1, ~^byte_data, byte_data, 1'b0};
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      // shifting in ones leaves the line idle after the stop bit
      shreg    <= {1'b1, shreg[FRAME_BITS-1:1]};
      if (bit_cnt == bit_cnt_t'(FRAME_BITS - 1))
      begin
        busy <= 1'b0;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // the line must be idle whenever a new byte may be accepted
  assert property (@(posedge clk) disable iff (!rst_n)
    byte_rdy |-> tx);

endmodule

// File: src/uart_frame_rx.sv
`timescale 1ns/1ps

module uart_frame_rx #(
  parameter int unsigned CLKS_PER_BIT = uart_cmd_pkg::BAUD_DIV
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  output uart_cmd_pkg::rx_frame_t frame,
  output logic                    frame_vld
);
  import uart_cmd_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_e;

  typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;
  typedef logic [$clog2(FRAME_BITS)-1:0]   bit_cnt_t;

  rx_state_e  state;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  baud_cnt_t  baud_cnt;
  bit_cnt_t   bit_cnt;
  logic [8:0] shreg;
  logic       start_edge;
  logic       half_bit;
  logic       full_bit;
  logic       stop_bit;

  assign start_edge = rx_prev && !rx_sync;
  assign half_bit   = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
  assign full_bit   = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
  // bit_cnt counts samples after the start bit, the last one is the stop bit
  assign stop_bit   = (bit_cnt == bit_cnt_t'(FRAME_BITS - 2));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= RX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      frame_vld <= 1'b0;
    end
    else
    begin
      frame_vld <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          if (start_edge)
          begin
            state <= RX_START;
          end
        end
        RX_START:
        begin
          if (half_bit)
          begin
            baud_cnt <= '0;
            // a glitch shorter than half a bit is not a start bit
            state    <= rx_sync ? RX_IDLE : RX_BITS;
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_BITS:
        begin
          if (full_bit)
          begin
            baud_cnt <= '0;
            if (stop_bit)
            begin
              frame_vld <= 1'b1;
              state     <= RX_IDLE;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == RX_BITS) && full_bit)
    begin
      if (stop_bit)
      begin
        frame.data <= shreg[7:0];
        // data plus parity must hold an odd count of ones
        frame.err  <= !(^shreg) || !rx_sync;
      end
      else
      begin
        shreg <= {rx_sync, shreg[8:1]};
      end
    end
  end

endmodule

// File: src/uart_cmd_master.sv
`timescale 1ns/1ps

module uart_cmd_master #(
  parameter int unsigned CLKS_PER_BIT = uart_cmd_pkg::BAUD_DIV
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output uart_cmd_pkg::rsp_t rsp,
  output logic               rsp_vld,
  input  logic               rx,
  output logic               tx
);
  import uart_cmd_pkg::*;

  cmd_t       job;
  logic       job_vld;
  logic       job_rdy;
  logic [7:0] byte_data;
  logic       byte_vld;
  logic       byte_rdy;
  rx_frame_t  frame;
  logic       frame_vld;

  uart_cmd_intake i_intake (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .job     (job),
    .job_vld (job_vld),
    .job_rdy (job_rdy)
  );

  uart_cmd_sequencer i_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .job       (job),
    .job_vld   (job_vld),
    .job_rdy   (job_rdy),
    .byte_data (byte_data),
    .byte_vld  (byte_vld),
    .byte_rdy  (byte_rdy),
    .frame     (frame),
    .frame_vld (frame_vld),
    .rsp       (rsp),
    .rsp_vld   (rsp_vld)
  );

  uart_frame_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_frame_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_data (byte_data),
    .byte_vld  (byte_vld),
    .byte_rdy  (byte_rdy),
    .tx        (tx)
  );

  uart_frame_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_frame_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .frame     (frame),
    .frame_vld (frame_vld)
  );

endmodule

// File: test/uart_cmd_checker.sv
`timescale 1ns/1ps

module uart_cmd_checker #(
  parameter int unsigned CLKS_PER_BIT = 16,
  parameter int          NUM_ENTRIES  = 1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  uart_cmd_pkg::cmd_t                    cmd,
  input  logic                                  cmd_vld,
  input  logic                                  cmd_rdy,
  input  uart_cmd_pkg::rsp_t                    rsp,
  input  logic                                  rsp_vld,
  input  logic                                  rx,
  input  logic                                  tx,
  input  uart_cmd_pkg::cmd_t [NUM_ENTRIES-1:0]  tbl_cmd,
  input  logic [NUM_ENTRIES-1:0][7:0]           tbl_rsp,
  input  logic [NUM_ENTRIES-1:0]                tbl_flip,
  output logic                                  done,
  output int                                    frame_errors,
  output int                                    rsp_errors,
  output int                                    hs_errors
);
  import uart_cmd_pkg::*;

  int unsigned cyc;
  // {data frame flag, byte}
  logic [8:0]  exp_frames[$];
  // {byte, err}
  logic [8:0]  exp_rsps[$];
  bit          frames_built;
  bit          rsps_built;
  int          frames_pending;
  int          rsps_pending;
  int          reads_seen;
  int          rsps_seen;
  int          accepted;
  int          stalls;
  logic        xfer_prev;
  bit          reset_checked;
  bit          stall_checked;

  assign done = frames_built && rsps_built && (frames_pending == 0) &&
                (rsps_pending == 0) && (accepted == NUM_ENTRIES);

  task automatic show_mismatch(input string name, input int unsigned got,
                               input int unsigned want);
    $display("ERROR %0t %s: got %0h, expected %0h", $time, name, got, want);
  endtask

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      xfer_prev = 1'b0;
    end
    else
    begin
      if (!reset_checked)
      begin
        reset_checked = 1'b1;
        if (tx !== 1'b1 || cmd_rdy !== 1'b1 || rsp_vld !== 1'b0)
        begin
          $display("ERROR %0t after reset: tx %b cmd_rdy %b rsp_vld %b, expected 1 1 0",
                   $time, tx, cmd_rdy, rsp_vld);
          hs_errors++;
        end
      end
      // the one-entry buffer is full in the cycle after a transfer
      if (xfer_prev && cmd_rdy)
      begin
        show_mismatch("cmd_rdy", 1, 0);
        hs_errors++;
      end
      xfer_prev = cmd_vld && cmd_rdy;
      if (cmd_vld && !cmd_rdy)
      begin
        stalls++;
      end
      if (cmd_vld && cmd_rdy)
      begin
        // commands must be taken one by one in table order
        if (accepted < NUM_ENTRIES && cmd !== tbl_cmd[accepted])
        begin
          show_mismatch("cmd", 32'(cmd), 32'(tbl_cmd[accepted]));
          hs_errors++;
        end
        accepted++;
      end
      if (done && !stall_checked)
      begin
        stall_checked = 1'b1;
        if (stalls == 0)
        begin
          $display("no command ever waited on cmd_rdy, back-to-back path not exercised");
          hs_errors++;
        end
      end
    end
  end

  initial
  begin : frame_check
    logic [FRAME_BITS-1:0] bits;
    logic [8:0]            exp;
    int                    i;
    int                    b;
    int                    start_cyc;
    int                    end_cyc;
    wait (rst_n === 1'b1);
    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      exp_frames.push_back({1'b0, tbl_cmd[i].op, tbl_cmd[i].addr});
      if (tbl_cmd[i].op == OP_WRITE)
      begin
        exp_frames.push_back({1'b1, tbl_cmd[i].data});
      end
    end
    frames_pending = exp_frames.size();
    frames_built   = 1'b1;
    end_cyc        = 0;
    forever
    begin
      @(posedge clk);
      if (!tx)
      begin
        start_cyc = cyc;
        if (rsps_seen != reads_seen)
        begin
          $display("a frame started on tx before the previous read was answered");
          frame_errors++;
        end
        // walk to the middle of the start bit, then take one sample per bit
        repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
        for (b = 0; b < FRAME_BITS; b++)
        begin
          bits[b] = tx;
          if (b < FRAME_BITS - 1)
          begin
            repeat (CLKS_PER_BIT) @(posedge clk);
          end
        end
        repeat (CLKS_PER_BIT - CLKS_PER_BIT / 2) @(posedge clk);
        if (exp_frames.size() == 0)
        begin
          $display("an extra frame appeared on tx carrying %02h", bits[8:1]);
          frame_errors++;
        end
        else
        begin
          exp = exp_frames.pop_front();
          if (bits[0] !== 1'b0)
          begin
            show_mismatch("tx start bit", 32'(bits[0]), 0);
            frame_errors++;
          end
          if (bits[8:1] !== exp[7:0])
          begin
            show_mismatch("tx data byte", 32'(bits[8:1]), 32'(exp[7:0]));
            frame_errors++;
          end
          // data and parity together must hold an odd number of ones
          if ((^bits[9:1]) !== 1'b1)
          begin
            show_mismatch("tx parity bit", 32'(bits[9]), 32'(!bits[9]));
            frame_errors++;
          end
          if (bits[10] !== 1'b1)
          begin
            show_mismatch("tx stop bit", 32'(bits[10]), 1);
            frame_errors++;
          end
          if (exp[8] && (start_cyc - end_cyc - 1 < int'(GAP_CYCLES)))
          begin
            $display("write gap too short at %0t: %0d idle cycles before the data frame",
                     $time, start_cyc - end_cyc - 1);
            frame_errors++;
          end
          if (!exp[8] && !exp[7])
          begin
            reads_seen++;
          end
          frames_pending--;
        end
        end_cyc = cyc;
      end
    end
  end

  initial
  begin : rsp_check
    logic [8:0] exp;
    int         i;
    wait (rst_n === 1'b1);
    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      if (tbl_cmd[i].op == OP_READ)
      begin
        exp_rsps.push_back({tbl_rsp[i], tbl_flip[i]});
      end
    end
    rsps_pending = exp_rsps.size();
    rsps_built   = 1'b1;
    forever
    begin
      @(posedge clk);
      if (rsp_vld)
      begin
        if ((rsps_seen >= reads_seen) || (exp_rsps.size() == 0))
        begin
          $display("rsp_vld pulsed at %0t with no read header waiting for it", $time);
          rsp_errors++;
        end
        else
        begin
          exp = exp_rsps.pop_front();
          if (rsp.data !== exp[8:1])
          begin
            show_mismatch("rsp.data", 32'(rsp.data), 32'(exp[8:1]));
            rsp_errors++;
          end
          if (rsp.err !== exp[0])
          begin
            show_mismatch("rsp.err", 32'(rsp.err), 32'(exp[0]));
            rsp_errors++;
          end
          rsps_seen++;
          rsps_pending--;
        end
      end
    end
  end

endmodule

// File: test/uart_cmd_master_tb.sv
`timescale 1ns/1ps

module uart_cmd_master_tb;
  import uart_cmd_pkg::*;

  localparam int unsigned CLKS_PER_BIT = 16;
  localparam int          NUM_ENTRIES  = 12;
  localparam int unsigned FRAME_CYCLES = FRAME_BITS * CLKS_PER_BIT;
  // per entry two frames, the write gap and one response frame, with a margin of two
  localparam int unsigned TIMEOUT_CYCLES = NUM_ENTRIES * (3 * FRAME_CYCLES + GAP_CYCLES) * 2;
  localparam int unsigned SEED = 32'hd101_c904;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd;
  logic        cmd_vld;
  logic        cmd_rdy;
  rsp_t        rsp;
  logic        rsp_vld;
  logic        rx;
  logic        tx;
  logic        done;
  int          frame_errors;
  int          rsp_errors;
  int          hs_errors;
  int unsigned cycles;

  // stimulus table, tbl_rsp is the byte a read is answered with
  cmd_t [NUM_ENTRIES-1:0]      tbl_cmd;
  logic [NUM_ENTRIES-1:0][7:0] tbl_rsp;
  logic [NUM_ENTRIES-1:0]      tbl_flip;

  uart_cmd_master #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_cmd_master (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .rx      (rx),
    .tx      (tx)
  );

  uart_cmd_checker #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .NUM_ENTRIES  (NUM_ENTRIES)
  ) i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .rsp          (rsp),
    .rsp_vld      (rsp_vld),
    .rx           (rx),
    .tx           (tx),
    .tbl_cmd      (tbl_cmd),
    .tbl_rsp      (tbl_rsp),
    .tbl_flip     (tbl_flip),
    .done         (done),
    .frame_errors (frame_errors),
    .rsp_errors   (rsp_errors),
    .hs_errors    (hs_errors)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic set_entry(input int idx, input cmd_op_e op, input logic [6:0] addr,
                           input logic [7:0] data, input logic [7:0] rsp_byte,
                           input logic flip);
    tbl_cmd[idx].op   = op;
    tbl_cmd[idx].addr = addr;
    tbl_cmd[idx].data = data;
    tbl_rsp[idx]      = rsp_byte;
    tbl_flip[idx]     = flip;
  endtask

  task automatic fill_table();
    int i;
    set_entry(0, OP_WRITE, 7'h00, 8'h00, 8'h00, 1'b0);
    set_entry(1, OP_WRITE, 7'h7f, 8'hff, 8'h00, 1'b0);
    set_entry(2, OP_READ, 7'h00, 8'h00, 8'h00, 1'b0);
    set_entry(3, OP_READ, 7'h7f, 8'h00, 8'hff, 1'b0);
    set_entry(4, OP_READ, 7'($urandom()), 8'h00, 8'($urandom()), 1'b1);
    for (i = 5; i < NUM_ENTRIES; i++)
    begin
      set_entry(i, ($urandom_range(1) == 1) ? OP_WRITE : OP_READ, 7'($urandom()),
                8'($urandom()), 8'($urandom()), $urandom_range(3) == 0);
    end
  endtask

  task automatic wait_frame_end();
    @(posedge clk);
    while (tx)
    begin
      @(posedge clk);
    end
    repeat (FRAME_CYCLES - 1) @(posedge clk);
  endtask

  // start, data lsb first, odd parity unless flipped, stop
  task automatic send_frame(input logic [7:0] data, input logic flip);
    logic [FRAME_BITS-1:0] bits;
    int                    b;
    bits = {1'b1, (~^data) ^ flip, data, 1'b0};
    for (b = 0; b < FRAME_BITS; b++)
    begin
      rx <= bits[b];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  initial
  begin : respond
    int i;
    wait (rst_n === 1'b1);
    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      wait_frame_end();
      if (tbl_cmd[i].op == OP_WRITE)
      begin
        wait_frame_end();
      end
      else
      begin
        send_frame(tbl_rsp[i], tbl_flip[i]);
      end
    end
  end

  initial
  begin : run
    int i;
    int total;
    void'($urandom(SEED));
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    cycles  = 0;
    fill_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (i = 0; i < NUM_ENTRIES; i++)
    begin
      cmd     <= tbl_cmd[i];
      cmd_vld <= 1'b1;
      @(posedge clk);
      while (!cmd_rdy)
      begin
        @(posedge clk);
      end
    end
    cmd_vld <= 1'b0;
    wait (done);
    // a stray trailing frame would start within this window
    repeat (FRAME_CYCLES + GAP_CYCLES) @(posedge clk);
    total = frame_errors + rsp_errors + hs_errors;
    $display("errors: frame %0d, response %0d, handshake %0d",
             frame_errors, rsp_errors, hs_errors);
    if (total == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: uart_cmd_master.f
src/uart_cmd_pkg.sv
src/uart_cmd_intake.sv
src/uart_cmd_sequencer.sv
src/uart_frame_tx.sv
src/uart_frame_rx.sv
src/uart_cmd_master.sv
test/uart_cmd_checker.sv
test/uart_cmd_master_tb.sv

// File: Makefile
TOP = uart_cmd_master_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f uart_cmd_master.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
